/* hdl/game_pkg.sv */
package game_pkg;

	//////////////////////////////////////////////////////////////////////
	// display geometry
	//////////////////////////////////////////////////////////////////////

	localparam int CELL_W    = 8;                             // bits per character cell
	localparam int ROW_CELLS = 16;                            // cells per display row

	localparam logic [1:0] ROW_GAME  = 2'd0;                  // objects and umbrella
	localparam logic [1:0] ROW_SCORE = 2'd1;                  // two score digits

	// cell 0 sits in the top bits, so row[i] is cell i
	typedef logic [0:ROW_CELLS-1][CELL_W-1:0] row_t;

	typedef struct packed {
		logic [1:0] row;                                      // target row index
		row_t       data;                                     // full row image
	} disp_wr_t;

	//////////////////////////////////////////////////////////////////////
	// glyph codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [CELL_W-1:0] GLYPH_NONE     = 8'h20;   // ascii space
	localparam logic [CELL_W-1:0] GLYPH_RAIN     = 8'h01;   // cgram slot 1
	localparam logic [CELL_W-1:0] GLYPH_BOLT     = 8'h02;   // cgram slot 2
	localparam logic [CELL_W-1:0] GLYPH_UMBRELLA = 8'h03;   // cgram slot 3
	localparam logic [CELL_W-1:0] GLYPH_DIGIT0   = 8'h30;   // ascii '0', '1'..'9' follow

	//////////////////////////////////////////////////////////////////////
	// game types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MODE_IDLE = 2'd0,                                     // game parked
		MODE_RAIN = 2'd1                                      // rainfall running
	} mode_t;

	// keypad scan codes, only 1 and 7 pick a side
	typedef enum logic [3:0] {
		KEY_0 = 4'h0, KEY_1 = 4'h1, KEY_2 = 4'h2, KEY_3 = 4'h3,
		KEY_4 = 4'h4, KEY_5 = 4'h5, KEY_6 = 4'h6, KEY_7 = 4'h7,
		KEY_8 = 4'h8, KEY_9 = 4'h9, KEY_A = 4'ha, KEY_B = 4'hb,
		KEY_C = 4'hc, KEY_D = 4'hd, KEY_E = 4'he, KEY_F = 4'hf
	} key_t;

	typedef enum logic {
		OBJ_RAIN = 1'b0,                                      // catch it
		OBJ_BOLT = 1'b1                                       // dodge it
	} obj_kind_t;

	// bit 1 kind, bit 0 lane, same layout as the random pair
	typedef struct packed {
		obj_kind_t kind;
		logic      left;                                      // 1 = left lane
	} obj_t;

	//////////////////////////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////////////////////////

	localparam logic [15:0] LFSR_SEED = 16'hace1;             // any nonzero value
	localparam logic [15:0] LFSR_TAPS = 16'hd008;             // x^16+x^15+x^13+x^4+1

endpackage

/* hdl/rand_lfsr.sv */
`timescale 1ns/1ns

module rand_lfsr (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           take,                           // game consumed rnd
	output game_pkg::obj_t rnd
);
	import game_pkg::*;

	logic [15:0] state;                                       // galois shift register

	// right-shifting galois form, feedback from bit 0
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= LFSR_SEED;
		else if (take)                                         // step only per hit
			state <= {1'b0, state[15:1]} ^ (state[0] ? LFSR_TAPS : 16'h0000);
	end

	assign rnd = state[1:0];                                  // kind, lane

	// a zero state would lock the sequence forever
	a_state_nonzero: assert property (
		@(posedge clk) disable iff (!rst_n)
		state != 16'h0000
	) else $error("lfsr state reached zero");

endmodule

/* hdl/rainfall_game.sv */
`timescale 1ns/1ns

module rainfall_game (
	input  logic               clk,
	input  logic               rst_n,
	input  game_pkg::mode_t    mode,
	input  logic               key_valid,              // one-cycle key strobe
	input  game_pkg::key_t     key,
	input  game_pkg::obj_t     rnd,                    // next object candidate
	output logic               take,                   // rnd consumed this cycle
	output logic               point,                  // one-cycle hit strobe
	output logic               game_req,               // row 0 write request
	output game_pkg::disp_wr_t game_wr
);
	import game_pkg::*;

	mode_t mode_q;                                            // previous mode
	logic  entry;                                             // first cycle in rain mode
	logic  active;                                            // keys count
	logic  side_key;                                          // key 1 or key 7
	logic  key_left;
	logic  hit;
	logic  strike;                                            // side key while active

	obj_t  q0, q1, q2;                                        // q0 is judged next
	obj_t  q0_n, q1_n, q2_n;
	logic  umb_vis, umb_left;                                 // umbrella drawn, and where
	logic  umb_vis_n, umb_left_n;
	logic  req_n;

	//////////////////////////////////////////////////////////////////////
	// row image helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [2*CELL_W-1:0] obj_cells(obj_t o);
		logic [CELL_W-1:0] g;
		g = (o.kind == OBJ_BOLT) ? GLYPH_BOLT : GLYPH_RAIN;
		return o.left ? {g, GLYPH_NONE} : {GLYPH_NONE, g};   // left cell first
	endfunction

	function automatic logic [2*CELL_W-1:0] umb_cells(logic vis, logic left);
		if (!vis)
			return {GLYPH_NONE, GLYPH_NONE};                  // no side chosen yet
		return left ? {GLYPH_UMBRELLA, GLYPH_NONE} : {GLYPH_NONE, GLYPH_UMBRELLA};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// hit judgement
	//////////////////////////////////////////////////////////////////////

	assign entry    = (mode == MODE_RAIN) && (mode_q != MODE_RAIN);
	assign active   = (mode == MODE_RAIN) && (mode_q == MODE_RAIN);
	assign key_left = (key == KEY_1);
	assign side_key = (key == KEY_1) || (key == KEY_7);
	assign strike   = active && key_valid && side_key;

	// rain wants the same side, bolt wants the other one
	assign hit  = side_key && (key_left == (q0.left ^ (q0.kind == OBJ_BOLT)));
	assign take = strike && hit;                              // shift pulls a new rnd

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		q0_n       = q0;
		q1_n       = q1;
		q2_n       = q2;
		umb_vis_n  = umb_vis;
		umb_left_n = umb_left;
		req_n      = 1'b0;
		if (entry)
		begin
			q2_n      = rnd;                                  // fresh fill, no take
			q1_n      = {rnd.left, rnd.kind};                 // bits swapped
			q0_n      = {rnd.kind, 1'b0};                     // kind only, right lane
			umb_vis_n = 1'b0;
			req_n     = 1'b1;
		end
		else if (strike)
		begin
			if (hit)
			begin
				q0_n = q1;                                    // advance the queue
				q1_n = q2;
				q2_n = rnd;
			end
			umb_vis_n  = 1'b1;
			umb_left_n = key_left;
			req_n      = 1'b1;                                // redraw on miss too
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode_q   <= MODE_IDLE;
			q0       <= '0;
			q1       <= '0;
			q2       <= '0;
			umb_vis  <= 1'b0;
			umb_left <= 1'b0;
			point    <= 1'b0;
			game_req <= 1'b0;
		end
		else
		begin
			mode_q   <= mode;
			q0       <= q0_n;
			q1       <= q1_n;
			q2       <= q2_n;
			umb_vis  <= umb_vis_n;
			umb_left <= umb_left_n;
			point    <= take;
			game_req <= req_n;
		end
	end

	// image tracks the next state, sampled only with game_req
	always_ff @(posedge clk)
	begin
		game_wr.row  <= ROW_GAME;
		game_wr.data <= {GLYPH_NONE, obj_cells(q2_n), GLYPH_NONE,
		                 GLYPH_NONE, obj_cells(q1_n), GLYPH_NONE,
		                 GLYPH_NONE, obj_cells(q0_n), GLYPH_NONE,
		                 GLYPH_NONE, umb_cells(umb_vis_n, umb_left_n), GLYPH_NONE};
	end

	a_take_keyed: assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> key_valid
	) else $error("take without a key strobe");

	// point lags the judging cycle by one
	a_point_in_rain: assert property (
		@(posedge clk) disable iff (!rst_n)
		point |-> ($past(mode) == MODE_RAIN)
	) else $error("point scored outside rain mode");

endmodule

/* hdl/score_keeper.sv */
`timescale 1ns/1ns

module score_keeper (
	input  logic               clk,
	input  logic               rst_n,
	input  game_pkg::mode_t    mode,
	input  logic               point,                  // hit strobe from the game
	output logic               score_req,              // row 1 write request
	output game_pkg::disp_wr_t score_wr
);
	import game_pkg::*;

	mode_t       mode_q;
	logic        entry;                                       // score clears here
	logic [3:0]  tens, units;                                 // bcd digits
	logic [3:0]  tens_n, units_n;

	assign entry = (mode == MODE_RAIN) && (mode_q != MODE_RAIN);

	// bcd increment, 99 rolls to 00
	always_comb
	begin
		tens_n  = tens;
		units_n = units;
		if (entry)
		begin
			tens_n  = 4'd0;
			units_n = 4'd0;
		end
		else if (point)
		begin
			if (units == 4'd9)
			begin
				units_n = 4'd0;                               // carry into tens
				tens_n  = (tens == 4'd9) ? 4'd0 : tens + 4'd1;
			end
			else
				units_n = units + 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode_q    <= MODE_IDLE;
			tens      <= 4'd0;
			units     <= 4'd0;
			score_req <= 1'b0;
		end
		else
		begin
			mode_q    <= mode;
			tens      <= tens_n;
			units     <= units_n;
			score_req <= entry || point;                      // redraw on every change
		end
	end

	// digits sit in the two rightmost cells
	always_ff @(posedge clk)
	begin
		score_wr.row  <= ROW_SCORE;
		score_wr.data <= {{(ROW_CELLS-2){GLYPH_NONE}},
		                  GLYPH_DIGIT0 + {4'd0, tens_n},
		                  GLYPH_DIGIT0 + {4'd0, units_n}};
	end

	a_bcd_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(tens <= 4'd9) && (units <= 4'd9)
	) else $error("score digit out of bcd range");

endmodule

/* hdl/disp_arbiter.sv */
`timescale 1ns/1ns

module disp_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [1:0]               req,              // per-writer strobes
	input  game_pkg::disp_wr_t [1:0] wr_in,
	output logic                     disp_we,          // one-cycle write strobe
	output game_pkg::disp_wr_t       disp_wr
);
	import game_pkg::*;

	logic     [1:0] slot_vld;                                 // pending slot full
	disp_wr_t [1:0] slot_data;                                // pending payloads
	logic     [1:0] full;                                     // slot or new request
	disp_wr_t [1:0] cand;                                     // latest value per port
	logic           last;                                     // port that won last
	logic           win;
	logic     [1:0] grant;

	//////////////////////////////////////////////////////////////////////
	// merge and pick
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			full[i] = slot_vld[i] | req[i];
			cand[i] = req[i] ? wr_in[i] : slot_data[i];       // newer value overwrites
		end
	end

	always_comb
	begin
		if (full[0] && full[1])
			win = ~last;                                      // alternate on contention
		else
			win = full[1];
		grant = 2'b00;
		if (|full)
			grant[win] = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// state and output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot_vld <= 2'b00;
			last     <= 1'b1;                                 // port 0 wins first tie
			disp_we  <= 1'b0;
		end
		else
		begin
			slot_vld <= full & ~grant;                        // loser keeps waiting
			disp_we  <= |grant;
			if (|grant)
				last <= win;
		end
	end

	always_ff @(posedge clk)
	begin
		slot_data <= cand;
		if (|grant)
			disp_wr <= cand[win];
	end

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(grant)
	) else $error("more than one grant");

	a_grant_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		(grant & ~full) == 2'b00
	) else $error("grant to an empty slot");

endmodule

/* hdl/game_top.sv */
`timescale 1ns/1ns

module game_top (
	input  logic               clk,
	input  logic               rst_n,
	input  game_pkg::mode_t    mode,
	input  logic               key_valid,
	input  game_pkg::key_t     key,
	output logic               point,
	output logic               disp_we,
	output game_pkg::disp_wr_t disp_wr
);
	import game_pkg::*;

	logic     take;                                           // game pulls a new object
	obj_t     rnd;
	logic     game_req, score_req;
	disp_wr_t game_wr, score_wr;

	rand_lfsr u_lfsr (
		.clk   (clk),
		.rst_n (rst_n),
		.take  (take),
		.rnd   (rnd)
	);

	rainfall_game u_game (
		.clk       (clk),
		.rst_n     (rst_n),
		.mode      (mode),
		.key_valid (key_valid),
		.key       (key),
		.rnd       (rnd),
		.take      (take),
		.point     (point),
		.game_req  (game_req),
		.game_wr   (game_wr)
	);

	score_keeper u_score (
		.clk       (clk),
		.rst_n     (rst_n),
		.mode      (mode),
		.point     (point),
		.score_req (score_req),
		.score_wr  (score_wr)
	);

	// port 0 game row, port 1 score row
	disp_arbiter u_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     ({score_req, game_req}),
		.wr_in   ({score_wr, game_wr}),
		.disp_we (disp_we),
		.disp_wr (disp_wr)
	);

endmodule

/* verification/tb_game_top.sv */
`timescale 1ns/1ns

module tb_game_top;
	import game_pkg::*;

	localparam int RAND_CYCLES = 500;                         // random key run length
	localparam int QUIET       = 6;                           // drain gap before row checks
	localparam int TIMEOUT_NS  = (RAND_CYCLES + 300) * 4 + 2000;

	logic     clk = 1'b0;
	logic     rst_n;
	mode_t    mode;
	logic     key_valid;
	key_t     key;
	logic     point;
	logic     disp_we;
	disp_wr_t disp_wr;

	logic [15:0] m_lfsr;                                      // model lfsr state
	obj_t        m_q0, m_q1, m_q2;                            // model queue
	logic        m_umb_vis, m_umb_left, m_in_rain;
	int          m_score, mark_pts, mark_we;
	int          exp_points = 0, seen_points = 0, we_count = 0;
	logic        hit_now = 1'b0, exp_point = 1'b0;            // point pipeline
	row_t        shadow0 = '0, shadow1 = '0;                  // display rows as written
	logic [31:0] rnd_word;

	game_top u_dut (.*);

	always #2 clk = ~clk;                                     // 4 ns period

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		logic [15:0] fb;
		fb = s[0] ? 16'hd008 : 16'h0000;                      // x^16+x^15+x^13+x^4 feedback
		return (s >> 1) ^ fb;
	endfunction

	function automatic logic want_left(obj_t o);
		return (o.kind == OBJ_RAIN) ? o.left : !o.left;       // a bolt is dodged
	endfunction

	function automatic logic key_hits(obj_t o, key_t k);
		if ((k != KEY_1) && (k != KEY_7))
			return 1'b0;                                      // no side, never a hit
		return (k == KEY_1) == want_left(o);
	endfunction

	function automatic key_t catch_key(obj_t o);
		return want_left(o) ? KEY_1 : KEY_7;
	endfunction

	function automatic int bcd_inc(int s);
		return (s + 1) % 100;                                 // 99 wraps to 00
	endfunction

	function automatic logic [CELL_W-1:0] obj_glyph(obj_t o);
		return (o.kind == OBJ_BOLT) ? GLYPH_BOLT : GLYPH_RAIN;
	endfunction

	function automatic row_t game_image(obj_t a0, obj_t a1, obj_t a2, logic uv, logic ul);
		row_t r;
		int   c;
		for (c = 0; c < ROW_CELLS; c++)
			r[c] = GLYPH_NONE;
		r[a2.left ? 1 : 2]  = obj_glyph(a2);                  // newest object
		r[a1.left ? 5 : 6]  = obj_glyph(a1);
		r[a0.left ? 9 : 10] = obj_glyph(a0);                  // object being judged
		if (uv)
			r[ul ? 13 : 14] = GLYPH_UMBRELLA;
		return r;
	endfunction

	function automatic row_t score_image(int s);
		row_t r;
		int   c;
		for (c = 0; c < ROW_CELLS; c++)
			r[c] = GLYPH_NONE;
		r[14] = GLYPH_DIGIT0 + 8'(s / 10);                    // tens
		r[15] = GLYPH_DIGIT0 + 8'(s % 10);                    // units
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks and stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(string name, logic [127:0] expv, logic [127:0] actv);
		if (expv !== actv)
		begin
			$display("FAIL %s exp=%h act=%h", name, expv, actv);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic abort_run(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;                                                   // drive just after the edge
	endtask

	task automatic compare_rows();
		repeat (QUIET) next_cycle();                          // let both writers drain
		check_val("row0", game_image(m_q0, m_q1, m_q2, m_umb_vis, m_umb_left), shadow0);
		check_val("row1", score_image(m_score), shadow1);
		check_val("points", 128'(exp_points), 128'(seen_points));
	endtask

	task automatic enter_rain();
		mode      = MODE_RAIN;
		m_q2      = obj_t'(m_lfsr[1:0]);                      // fill without a take
		m_q1      = obj_t'({m_lfsr[0], m_lfsr[1]});           // lane and kind swapped
		m_q0      = obj_t'({m_lfsr[1], 1'b0});                // kind only, right lane
		m_umb_vis = 1'b0;
		m_score   = 0;
		m_in_rain = 1'b1;
		next_cycle();                                         // entry cycle, no keys
	endtask

	task automatic strike_key(key_t k);
		logic hit;
		hit       = m_in_rain && key_hits(m_q0, k);
		key       = k;
		key_valid = 1'b1;
		hit_now   = hit;
		if (m_in_rain && ((k == KEY_1) || (k == KEY_7)))
		begin
			m_umb_vis  = 1'b1;
			m_umb_left = (k == KEY_1);                        // umbrella follows the key
		end
		if (hit)
		begin
			m_q0       = m_q1;
			m_q1       = m_q2;
			m_q2       = obj_t'(m_lfsr[1:0]);                 // drawn before the step
			m_lfsr     = lfsr_step(m_lfsr);
			m_score    = bcd_inc(m_score);
			exp_points = exp_points + 1;
		end
		next_cycle();
		key_valid = 1'b0;
		hit_now   = 1'b0;
	endtask

	always @(posedge clk)
		exp_point <= hit_now;                                 // point lags the key by one

	// point strobe and write port sampled mid-cycle
	always @(negedge clk)
	begin
		check_val("point", 128'(exp_point), 128'(point));
		if (point)
			seen_points = seen_points + 1;
		if (rst_n && disp_we)
		begin
			we_count = we_count + 1;
			if (disp_wr.row == ROW_GAME)
				shadow0 = disp_wr.data;
			else if (disp_wr.row == ROW_SCORE)
				shadow1 = disp_wr.data;
			else
				abort_run($sformatf("display write to unknown row %0d", disp_wr.row));
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout, run went past %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		rnd_word   = $urandom(32'hadad_d849);                 // single seed for the run
		rst_n      = 1'b0;
		mode       = MODE_IDLE;
		key_valid  = 1'b0;
		key        = KEY_0;
		m_lfsr     = LFSR_SEED;
		m_in_rain  = 1'b0;
		m_umb_vis  = 1'b0;
		m_umb_left = 1'b0;
		m_score    = 0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (3) next_cycle();

		enter_rain();                                         // seed fill, score 00
		compare_rows();
		repeat (8)
		begin
			strike_key(catch_key(m_q0));                      // catch or dodge
			compare_rows();
		end
		strike_key(catch_key(m_q0) == KEY_1 ? KEY_7 : KEY_1); // wrong side
		compare_rows();
		strike_key(KEY_5);                                    // no side at all
		compare_rows();

		mark_pts = exp_points;
		repeat (RAND_CYCLES)
		begin
			rnd_word = $urandom;
			if (rnd_word[1:0] != 2'b00)
				strike_key(rnd_word[2] ? KEY_1 : KEY_7);      // mostly side keys
			else
				strike_key(key_t'(rnd_word[7:4]));
		end
		compare_rows();
		if (exp_points - mark_pts <= 100)
			abort_run("random run scored too few hits to wrap the score");

		mode      = MODE_IDLE;
		m_in_rain = 1'b0;
		compare_rows();
		mark_we = we_count;
		repeat (6) strike_key(catch_key(m_q0));               // ignored while idle
		compare_rows();
		check_val("idle_writes", 128'(mark_we), 128'(we_count));
		enter_rain();                                         // refill from current lfsr
		compare_rows();
		repeat (4)
		begin
			strike_key(catch_key(m_q0));
			compare_rows();
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* vlog.f */
hdl/game_pkg.sv
hdl/rand_lfsr.sv
hdl/rainfall_game.sv
hdl/score_keeper.sv
hdl/disp_arbiter.sv
hdl/game_top.sv
verification/tb_game_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rainfall game testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f vlog.f --top-module tb_game_top -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if grep -q "ALL CHECKS PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1
